// ==== conv2x2_top.f ====
design/conv_pkg.sv
design/line_buffer.sv
design/window_control.sv
design/kernel_regs.sv
design/conv_mac.sv
design/conv2x2_top.sv
tests/conv2x2_tb.sv

// ==== tests/conv2x2_tb.sv ====
module conv2x2_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 10;
	localparam int TOTAL_FRAMES = 9; // 1 + 1 + 1 + 1 + 2 + 3
	localparam int PAIRS_PER_FRAME = conv_pkg::IMG_SIZE * conv_pkg::PAIRS_PER_ROW;
	localparam int RESULTS_PER_FRAME = conv_pkg::OUT_ROWS * conv_pkg::OUT_COLS;
	localparam int WATCHDOG_NS = TOTAL_FRAMES * PAIRS_PER_FRAME * 4 * CLK_PERIOD + 2000;

	logic clk;
	logic reset;
	logic pixel_valid;
	conv_pkg::pixel_t pixel_even;
	conv_pkg::pixel_t pixel_odd;
	logic coef_write;
	conv_pkg::coef_addr_t coef_addr;
	conv_pkg::coef_t coef_data;
	logic result_valid;
	logic result_last;
	conv_pkg::pixel_t result_data;

	conv_pkg::pixel_t image [conv_pkg::IMG_SIZE][conv_pkg::IMG_SIZE];
	conv_pkg::coef_t coefs [5]; // TL, TR, BL, BR, bias

	int exp_data_q [$];
	bit exp_last_q [$];

	string test_name;
	int test_errors;
	int results_seen;
	int lasts_seen;
	int saturated_seen;
	int pass_count;
	int fail_count;
	int expected_data;
	bit expected_last;

	conv2x2_top i_conv2x2_top (
		.clk(clk),
		.reset(reset),
		.pixel_valid(pixel_valid),
		.pixel_even(pixel_even),
		.pixel_odd(pixel_odd),
		.coef_write(coef_write),
		.coef_addr(coef_addr),
		.coef_data(coef_data),
		.result_valid(result_valid),
		.result_last(result_last),
		.result_data(result_data)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, results stopped arriving", WATCHDOG_NS);
		$display("SOME TESTS FAILED");
		$finish;
	end

	task automatic check_value(input string label, input int expected, input int actual);
		if (expected != actual)
		begin
			$display("Error in %s, %s: expected %0d, actual %0d", test_name, label, expected,
				actual);
			test_errors++;
		end
	endtask

	// Dot product, bias, shift, ReLU and clamp for one window
	function automatic int conv_ref(input int tl, input int tr, input int bl, input int br);
		int sum;
		int scaled;
		sum = tl * coefs[0] + tr * coefs[1] + bl * coefs[2] + br * coefs[3] + coefs[4];
		scaled = sum >>> conv_pkg::FRAC_BITS;
		if (scaled < 0)
		begin
			return 0;
		end
		if (scaled > 255)
		begin
			return 255;
		end
		return scaled;
	endfunction

	// Results are sampled half a cycle after the edge that produced them
	always @(negedge clk)
	begin
		if (!reset && result_valid)
		begin
			results_seen++;
			if (result_last)
			begin
				lasts_seen++;
			end
			if (result_data == 8'd255)
			begin
				saturated_seen++;
			end
			if (exp_data_q.size() == 0)
			begin
				$display("%s: result %0d arrived with no expected value left", test_name,
					result_data);
				test_errors++;
			end
			else
			begin
				expected_data = exp_data_q.pop_front();
				expected_last = exp_last_q.pop_front();
				check_value("result_data", expected_data, int'(result_data));
				check_value("result_last", int'(expected_last), int'(result_last));
			end
		end
		else if (!reset && result_last)
		begin
			$display("%s: result_last pulsed without result_valid", test_name);
			test_errors++;
		end
	end

	task automatic set_coefs(input int tl, input int tr, input int bl, input int br, input int b);
		coefs[0] = conv_pkg::coef_t'(tl);
		coefs[1] = conv_pkg::coef_t'(tr);
		coefs[2] = conv_pkg::coef_t'(bl);
		coefs[3] = conv_pkg::coef_t'(br);
		coefs[4] = conv_pkg::coef_t'(b);
	endtask

	task automatic write_coef(input int addr, input int data);
		@(posedge clk);
		#1;
		coef_write = 1'b1;
		coef_addr = conv_pkg::coef_addr_t'(addr);
		coef_data = conv_pkg::coef_t'(data);
	endtask

	task automatic load_coefs();
		for (int a = 0; a <= conv_pkg::COEF_ADDR_BIAS; a++)
		begin
			write_coef(a, coefs[a]);
		end
		write_coef(5, 16'h7fff); // Unused addresses leave the weights alone
		write_coef(7, -1);
		@(posedge clk);
		#1;
		coef_write = 1'b0;
		coef_addr = '0;
		coef_data = '0;
	endtask

	task automatic fill_random_image(input int lo, input int hi);
		for (int r = 0; r < conv_pkg::IMG_SIZE; r++)
		begin
			for (int c = 0; c < conv_pkg::IMG_SIZE; c++)
			begin
				image[r][c] = conv_pkg::pixel_t'($urandom_range(hi, lo));
			end
		end
	endtask

	task automatic fill_pattern_image(input int offset);
		for (int r = 0; r < conv_pkg::IMG_SIZE; r++)
		begin
			for (int c = 0; c < conv_pkg::IMG_SIZE; c++)
			begin
				image[r][c] = conv_pkg::pixel_t'(r * 31 + c * 7 + r * c + offset);
			end
		end
	endtask

	// Rows 1 to 27 in raster order, last window tagged
	task automatic queue_expected();
		for (int r = 1; r < conv_pkg::IMG_SIZE; r++)
		begin
			for (int p = 0; p < conv_pkg::PAIRS_PER_ROW; p++)
			begin
				exp_data_q.push_back(conv_ref(image[r - 1][2 * p], image[r - 1][2 * p + 1],
					image[r][2 * p], image[r][2 * p + 1]));
				exp_last_q.push_back((r == conv_pkg::IMG_SIZE - 1)
					&& (p == conv_pkg::PAIRS_PER_ROW - 1));
			end
		end
	endtask

	task automatic stream_image(input int max_gap);
		int gap;
		for (int r = 0; r < conv_pkg::IMG_SIZE; r++)
		begin
			for (int p = 0; p < conv_pkg::PAIRS_PER_ROW; p++)
			begin
				@(posedge clk);
				#1;
				pixel_valid = 1'b1;
				pixel_even = image[r][2 * p];
				pixel_odd = image[r][2 * p + 1];
				gap = (max_gap > 0) ? $urandom_range(max_gap, 0) : 0;
				repeat (gap)
				begin
					@(posedge clk);
					#1;
					pixel_valid = 1'b0;
					pixel_even = '0;
					pixel_odd = '0;
				end
			end
		end
		@(posedge clk);
		#1;
		pixel_valid = 1'b0;
		pixel_even = '0;
		pixel_odd = '0;
	endtask

	task automatic run_frame(input int max_gap);
		load_coefs();
		queue_expected();
		stream_image(max_gap);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
		results_seen = 0;
		lasts_seen = 0;
		saturated_seen = 0;
	endtask

	task automatic drain_results();
		int waited;
		waited = 0;
		while (exp_data_q.size() != 0 && waited < 20)
		begin
			@(posedge clk);
			waited++;
		end
		repeat (5) @(posedge clk); // Catch stray results
	endtask

	task automatic finish_test(input int frames);
		drain_results();
		if (exp_data_q.size() != 0)
		begin
			$display("%s: %0d expected results never appeared", test_name, exp_data_q.size());
			test_errors++;
			exp_data_q.delete();
			exp_last_q.delete();
		end
		check_value("result count", frames * RESULTS_PER_FRAME, results_seen);
		check_value("result_last count", frames, lasts_seen);
		if (test_errors == 0)
		begin
			$display("Test %s passed", test_name);
			pass_count++;
		end
		else
		begin
			$display("Test %s failed with %0d errors", test_name, test_errors);
			fail_count++;
		end
	endtask

	initial
	begin
		void'($urandom(64));
		reset = 1'b1;
		pixel_valid = 1'b0;
		pixel_even = '0;
		pixel_odd = '0;
		coef_write = 1'b0;
		coef_addr = '0;
		coef_data = '0;
		pass_count = 0;
		fail_count = 0;
		test_name = "reset";
		test_errors = 0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		start_test("pass_through");
		set_coefs(0, 0, 0, 256, 0);
		fill_pattern_image(3);
		run_frame(0);
		finish_test(1);

		start_test("vertical_alignment");
		set_coefs(256, 0, 0, 0, 0);
		fill_random_image(0, 255);
		run_frame(0);
		finish_test(1);

		start_test("random_with_gaps");
		set_coefs($urandom_range(383, 0) - 128, $urandom_range(383, 0) - 128,
			$urandom_range(383, 0) - 128, $urandom_range(383, 0) - 128,
			$urandom_range(8191, 0) - 4096);
		fill_random_image(0, 255);
		run_frame(2);
		finish_test(1);

		start_test("relu");
		set_coefs(-$urandom_range(2000, 1), -$urandom_range(2000, 1),
			-$urandom_range(2000, 1), -$urandom_range(2000, 1), -$urandom_range(30000, 1));
		fill_random_image(0, 255);
		run_frame(0);
		finish_test(1);

		start_test("saturation");
		set_coefs(16000, 16000, 16000, 16000, 0);
		fill_random_image(200, 255);
		run_frame(0);
		set_coefs(128, 128, 128, 128, 0);
		fill_random_image(0, 255);
		run_frame(0);
		drain_results();
		if (saturated_seen <= RESULTS_PER_FRAME || saturated_seen >= 2 * RESULTS_PER_FRAME)
		begin
			$display("saturation: mixed frame did not give both clamped and unclamped results");
			test_errors++;
		end
		finish_test(2);

		start_test("frame_sequence");
		set_coefs(100, -50, 75, 200, 1000);
		fill_pattern_image(0);
		run_frame(0);
		set_coefs(-30, 180, 90, 20, -2000);
		fill_random_image(0, 255);
		run_frame(0);
		set_coefs(64, 64, 64, 64, 512);
		fill_pattern_image(100);
		run_frame(0);
		finish_test(3);

		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
		begin
			$display("ALL TESTS PASSED");
		end
		else
		begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== design/conv2x2_top.sv ====
module conv2x2_top (
	input logic clk,
	input logic reset,
	input logic pixel_valid,
	input conv_pkg::pixel_t pixel_even,
	input conv_pkg::pixel_t pixel_odd,
	input logic coef_write,
	input conv_pkg::coef_addr_t coef_addr,
	input conv_pkg::coef_t coef_data,
	output logic result_valid,
	output logic result_last,
	output conv_pkg::pixel_t result_data
);

	// 2x2 window taps
	conv_pkg::pixel_t tap_top_left;
	conv_pkg::pixel_t tap_top_right;
	conv_pkg::pixel_t tap_bottom_left;
	conv_pkg::pixel_t tap_bottom_right;

	logic window_valid;
	logic window_last;

	// Coefficients
	conv_pkg::coef_t weight_top_left;
	conv_pkg::coef_t weight_top_right;
	conv_pkg::coef_t weight_bottom_left;
	conv_pkg::coef_t weight_bottom_right;
	conv_pkg::coef_t bias;

	line_buffer i_line_buffer (
		.clk(clk),
		.reset(reset),
		.shift_enable(pixel_valid),
		.pixel_even(pixel_even),
		.pixel_odd(pixel_odd),
		.tap_top_left(tap_top_left),
		.tap_top_right(tap_top_right),
		.tap_bottom_left(tap_bottom_left),
		.tap_bottom_right(tap_bottom_right)
	);

	window_control i_window_control (
		.clk(clk),
		.reset(reset),
		.pixel_valid(pixel_valid),
		.window_valid(window_valid),
		.window_last(window_last)
	);

	kernel_regs i_kernel_regs (
		.clk(clk),
		.reset(reset),
		.coef_write(coef_write),
		.coef_addr(coef_addr),
		.coef_data(coef_data),
		.weight_top_left(weight_top_left),
		.weight_top_right(weight_top_right),
		.weight_bottom_left(weight_bottom_left),
		.weight_bottom_right(weight_bottom_right),
		.bias(bias)
	);

	conv_mac i_conv_mac (
		.clk(clk),
		.reset(reset),
		.window_valid(window_valid),
		.window_last(window_last),
		.tap_top_left(tap_top_left),
		.tap_top_right(tap_top_right),
		.tap_bottom_left(tap_bottom_left),
		.tap_bottom_right(tap_bottom_right),
		.weight_top_left(weight_top_left),
		.weight_top_right(weight_top_right),
		.weight_bottom_left(weight_bottom_left),
		.weight_bottom_right(weight_bottom_right),
		.bias(bias),
		.result_valid(result_valid),
		.result_last(result_last),
		.result_data(result_data)
	);

endmodule

// ==== design/conv_mac.sv ====
module conv_mac (
	input logic clk,
	input logic reset,
	input logic window_valid,
	input logic window_last,
	input conv_pkg::pixel_t tap_top_left,
	input conv_pkg::pixel_t tap_top_right,
	input conv_pkg::pixel_t tap_bottom_left,
	input conv_pkg::pixel_t tap_bottom_right,
	input conv_pkg::coef_t weight_top_left,
	input conv_pkg::coef_t weight_top_right,
	input conv_pkg::coef_t weight_bottom_left,
	input conv_pkg::coef_t weight_bottom_right,
	input conv_pkg::coef_t bias,
	output logic result_valid,
	output logic result_last,
	output conv_pkg::pixel_t result_data
);

	// Pixel is unsigned, so widen with a zero sign bit first
	function automatic conv_pkg::acc_t pixel_times_weight(
		input conv_pkg::pixel_t pixel,
		input conv_pkg::coef_t weight
	);
		logic signed [8:0] pixel_signed;
		pixel_signed = $signed({1'b0, pixel});
		return conv_pkg::acc_t'(pixel_signed * weight);
	endfunction

	// Stage 1 registers
	conv_pkg::acc_t prod_top_left;
	conv_pkg::acc_t prod_top_right;
	conv_pkg::acc_t prod_bottom_left;
	conv_pkg::acc_t prod_bottom_right;
	conv_pkg::coef_t bias_s1;
	logic valid_s1;
	logic last_s1;

	// Stage 2 combinational path
	conv_pkg::acc_t sum;
	conv_pkg::acc_t scaled;
	conv_pkg::pixel_t clamped;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			prod_top_left <= '0;
			prod_top_right <= '0;
			prod_bottom_left <= '0;
			prod_bottom_right <= '0;
			bias_s1 <= '0;
			valid_s1 <= 1'b0;
			last_s1 <= 1'b0;
		end
		else
		begin
			prod_top_left <= pixel_times_weight(tap_top_left, weight_top_left);
			prod_top_right <= pixel_times_weight(tap_top_right, weight_top_right);
			prod_bottom_left <= pixel_times_weight(tap_bottom_left, weight_bottom_left);
			prod_bottom_right <= pixel_times_weight(tap_bottom_right, weight_bottom_right);
			bias_s1 <= bias;
			valid_s1 <= window_valid;
			last_s1 <= window_valid && window_last;
		end
	end

	always_comb
	begin
		sum = prod_top_left + prod_top_right + prod_bottom_left + prod_bottom_right
			+ conv_pkg::acc_t'(bias_s1); // Bias sign extended
		scaled = sum >>> conv_pkg::FRAC_BITS;
		if (scaled < 0)
		begin
			clamped = '0; // ReLU
		end
		else if (scaled > conv_pkg::acc_t'(255))
		begin
			clamped = 8'd255; // Saturate
		end
		else
		begin
			clamped = scaled[7:0];
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			result_data <= '0;
			result_valid <= 1'b0;
			result_last <= 1'b0;
		end
		else
		begin
			result_data <= clamped;
			result_valid <= valid_s1;
			result_last <= last_s1;
		end
	end

endmodule

// ==== design/kernel_regs.sv ====
module kernel_regs (
	input logic clk,
	input logic reset,
	input logic coef_write,
	input conv_pkg::coef_addr_t coef_addr,
	input conv_pkg::coef_t coef_data,
	output conv_pkg::coef_t weight_top_left,
	output conv_pkg::coef_t weight_top_right,
	output conv_pkg::coef_t weight_bottom_left,
	output conv_pkg::coef_t weight_bottom_right,
	output conv_pkg::coef_t bias
);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			weight_top_left <= '0;
			weight_top_right <= '0;
			weight_bottom_left <= '0;
			weight_bottom_right <= '0;
			bias <= '0;
		end
		else if (coef_write)
		begin
			case (coef_addr)
				conv_pkg::coef_addr_t'(0): weight_top_left <= coef_data;
				conv_pkg::coef_addr_t'(1): weight_top_right <= coef_data;
				conv_pkg::coef_addr_t'(2): weight_bottom_left <= coef_data;
				conv_pkg::coef_addr_t'(3): weight_bottom_right <= coef_data;
				conv_pkg::coef_addr_t'(conv_pkg::COEF_ADDR_BIAS): bias <= coef_data;
				default: ; // Addresses 5 to 7 unused
			endcase
		end
	end

endmodule

// ==== design/window_control.sv ====
module window_control (
	input logic clk,
	input logic reset,
	input logic pixel_valid,
	output logic window_valid,
	output logic window_last
);

	conv_pkg::pair_cnt_t pair_cnt;
	conv_pkg::row_cnt_t row_cnt;
	logic row_end;
	logic frame_end;
	logic in_output_rows;

	// Position of the pair being accepted this cycle
	assign row_end = (pair_cnt == conv_pkg::pair_cnt_t'(conv_pkg::OUT_COLS - 1));
	assign frame_end = row_end && (row_cnt == conv_pkg::row_cnt_t'(conv_pkg::OUT_ROWS));
	assign in_output_rows = (row_cnt != '0); // Row 0 has no row above

	// Pair and row counters
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			pair_cnt <= '0;
			row_cnt <= '0;
		end
		else if (pixel_valid)
		begin
			if (row_end)
			begin
				pair_cnt <= '0;
				if (frame_end)
				begin
					row_cnt <= '0; // Next frame may follow at once
				end
				else
				begin
					row_cnt <= row_cnt + 1'b1;
				end
			end
			else
			begin
				pair_cnt <= pair_cnt + 1'b1;
			end
		end
	end

	// Flags line up with the line buffer taps
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			window_valid <= 1'b0;
			window_last <= 1'b0;
		end
		else
		begin
			window_valid <= pixel_valid && in_output_rows;
			window_last <= pixel_valid && frame_end;
		end
	end

endmodule

// ==== design/line_buffer.sv ====
module line_buffer (
	input logic clk,
	input logic reset,
	input logic shift_enable,
	input conv_pkg::pixel_t pixel_even,
	input conv_pkg::pixel_t pixel_odd,
	output conv_pkg::pixel_t tap_top_left,
	output conv_pkg::pixel_t tap_top_right,
	output conv_pkg::pixel_t tap_bottom_left,
	output conv_pkg::pixel_t tap_bottom_right
);

	// Entry 0 holds the newest even pixel, entry 1 the newest odd pixel.
	// A pair accepted k enables ago sits at entries 2k and 2k+1.
	conv_pkg::pixel_t entries [conv_pkg::LINE_DEPTH];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < conv_pkg::LINE_DEPTH; i++)
			begin
				entries[i] <= '0;
			end
		end
		else if (shift_enable)
		begin
			entries[0] <= pixel_even;
			entries[1] <= pixel_odd;
			for (int i = 2; i < conv_pkg::LINE_DEPTH; i++)
			begin
				entries[i] <= entries[i - 2]; // Two places per enable
			end
		end
	end

	// Newest pair
	assign tap_bottom_left = entries[0];
	assign tap_bottom_right = entries[1];

	// Same columns, PAIRS_PER_ROW enables older
	assign tap_top_left = entries[conv_pkg::LINE_DEPTH - 2];
	assign tap_top_right = entries[conv_pkg::LINE_DEPTH - 1];

endmodule

// ==== design/conv_pkg.sv ====
package conv_pkg;

	// Image and window geometry
	localparam int IMG_SIZE = 28;
	localparam int KERNEL_SIZE = 2;
	localparam int PAIRS_PER_ROW = IMG_SIZE / 2; // Two pixels per input beat
	localparam int LINE_DEPTH = (KERNEL_SIZE - 1) * IMG_SIZE + KERNEL_SIZE;

	// Output grid, one result per pair in rows 1 and up
	localparam int OUT_ROWS = IMG_SIZE - KERNEL_SIZE + 1;
	localparam int OUT_COLS = PAIRS_PER_ROW;

	// Arithmetic
	localparam int FRAC_BITS = 8; // Fixed point scaling of the weights

	// Coefficient map: 0..3 weights TL, TR, BL, BR
	localparam int COEF_ADDR_BIAS = 4;

	typedef logic [7:0] pixel_t;
	typedef logic signed [15:0] coef_t;
	typedef logic signed [27:0] acc_t; // Four products plus bias
	typedef logic [2:0] coef_addr_t;
	typedef logic [4:0] row_cnt_t;
	typedef logic [3:0] pair_cnt_t;

endpackage
